// File: verilog/dcache_geometry_pkg.sv
// data cache geometry: address split, line format and way select encoding
package dcache_geometry_pkg;

  // fixed at four ways by the 3-bit tree pseudo-LRU
  localparam int num_ways = 4;
  localparam int num_sets = 32;

  localparam int index_bits = 5;
  localparam int offset_bits = 3;
  localparam int tag_bits = 24;
  localparam int data_bits = 64;

  // byte address as tag / set / offset
  typedef struct packed {
    logic [tag_bits-1:0]    tag;
    logic [index_bits-1:0]  set_index;
    logic [offset_bits-1:0] offset;
  } addr_fields_t;

  // one address word, read flat by memory or split by the ways
  typedef union packed {
    logic [31:0]  word;
    addr_fields_t fields;
  } dcache_addr_u;

  // one stored line, 90 bits
  typedef struct packed {
    logic                 valid;
    logic                 dirty;
    logic [tag_bits-1:0]  tag;
    logic [data_bits-1:0] data;
  } cache_line_t;

  // one-hot way vector
  typedef logic [num_ways-1:0] way_sel_t;

endpackage

// File: verilog/dcache_port_pkg.sv
// data cache port structs: write requests and evicted lines
package dcache_port_pkg;

  // write request shared by stores and fills, 97 bits
  typedef struct packed {
    dcache_geometry_pkg::dcache_addr_u                  addr;
    logic [dcache_geometry_pkg::data_bits-1:0]          data;
    logic                                               dirty;
  } wr_req_t;

  // line leaving the cache, 98 bits
  // addr is stored tag plus write index, offset zero
  typedef struct packed {
    logic                                               valid;
    logic                                               dirty;
    dcache_geometry_pkg::dcache_addr_u                  addr;
    logic [dcache_geometry_pkg::data_bits-1:0]          data;
  } victim_t;

endpackage

// File: verilog/cache_way.sv
// one cache way: per-set lines, read and write tag checks, victim readout
`timescale 1ns/100ps

module cache_way (
  input  logic                              clock,
  input  logic                              reset,
  input  logic                              wr_en,
  input  dcache_geometry_pkg::dcache_addr_u rd_addr,
  input  dcache_port_pkg::wr_req_t          wr_req,
  output logic                              rd_hit,
  output logic [63:0]                       rd_data,
  output logic                              wr_hit,
  output dcache_port_pkg::victim_t          victim
);

  import dcache_geometry_pkg::*;

  cache_line_t lines [num_sets];

  logic [index_bits-1:0] rd_idx;
  logic [index_bits-1:0] wr_idx;

  assign rd_idx = rd_addr.fields.set_index;
  assign wr_idx = wr_req.addr.fields.set_index;

  // read port tag check
  assign rd_hit = lines[rd_idx].valid && (lines[rd_idx].tag == rd_addr.fields.tag);
  assign rd_data = lines[rd_idx].data;

  // write port tag check
  assign wr_hit = lines[wr_idx].valid && (lines[wr_idx].tag == wr_req.addr.fields.tag);

  // line at the write index, as it would leave on a fill
  assign victim.valid = lines[wr_idx].valid;
  assign victim.dirty = lines[wr_idx].dirty;
  assign victim.addr.fields.tag = lines[wr_idx].tag;
  assign victim.addr.fields.set_index = wr_idx;
  assign victim.addr.fields.offset = '0;
  assign victim.data = lines[wr_idx].data;

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < num_sets; i++) begin
        lines[i] <= '0;
      end
    end else if (wr_en) begin
      // store and fill both leave the line valid
      lines[wr_idx].valid <= 1'b1;
      lines[wr_idx].dirty <= wr_req.dirty;
      lines[wr_idx].tag <= wr_req.addr.fields.tag;
      lines[wr_idx].data <= wr_req.data;
    end
  end

  // written index names a real set
  a_write_lands: assert property (
    @(posedge clock) disable iff (reset)
    wr_en |-> !$isunknown(wr_idx)
  );

endmodule

// File: verilog/plru_tree.sv
// tree pseudo-LRU per set: three bits each, one-hot victim out
`timescale 1ns/100ps

module plru_tree (
  input  logic                                         clock,
  input  logic                                         reset,
  input  logic                                         fill_strobe,
  input  logic [dcache_geometry_pkg::index_bits-1:0]   fill_set,
  input  logic [dcache_geometry_pkg::index_bits-1:0]   victim_set,
  output dcache_geometry_pkg::way_sel_t                victim_way
);

  import dcache_geometry_pkg::*;

  // root picks the half, left picks in ways 0/1, right in ways 2/3
  logic [num_sets-1:0] root;
  logic [num_sets-1:0] left;
  logic [num_sets-1:0] right;

  logic cur_root;
  logic cur_left;
  logic cur_right;

  assign cur_root = root[victim_set];
  assign cur_left = left[victim_set];
  assign cur_right = right[victim_set];

  // victim from the current bits
  always_comb begin
    victim_way = '0;
    if (!cur_root) begin
      victim_way[cur_left ? 1 : 0] = 1'b1;
    end else begin
      victim_way[cur_right ? 3 : 2] = 1'b1;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      root <= '0;
      left <= '0;
      right <= '0;
    end else if (fill_strobe) begin
      root[fill_set] <= ~root[fill_set];
      // only the side the old root pointed at moves
      if (!root[fill_set]) begin
        left[fill_set] <= ~left[fill_set];
      end else begin
        right[fill_set] <= ~right[fill_set];
      end
    end
  end

  a_victim_onehot: assert property (
    @(posedge clock) disable iff (reset)
    $onehot(victim_way)
  );

endmodule

// File: verilog/writeback_buffer.sv
// writeback buffer: FIFO of evicted dirty lines until memory takes them
`timescale 1ns/100ps

module writeback_buffer #(
  parameter int wb_depth = 2
) (
  input  logic                     clock,
  input  logic                     reset,
  input  logic                     push,
  input  dcache_port_pkg::victim_t push_line,
  input  logic                     wb_done,
  output logic                     wb_valid,
  output dcache_port_pkg::victim_t wb_line,
  output logic                     wb_full
);

  import dcache_port_pkg::*;

  localparam int ptr_bits = (wb_depth > 1) ? $clog2(wb_depth) : 1;
  localparam int cnt_bits = $clog2(wb_depth + 1);

  victim_t entries [wb_depth];

  logic [ptr_bits-1:0] wr_ptr;
  logic [ptr_bits-1:0] rd_ptr;
  logic [cnt_bits-1:0] count;
  logic                pop;
  logic                wr_accept;

  assign wb_valid = (count != '0);
  assign wb_full = (count == cnt_bits'(wb_depth));
  assign wb_line = entries[rd_ptr];

  assign pop = wb_done && wb_valid;
  // a pop in the same cycle frees the slot
  assign wr_accept = push && (!wb_full || pop);

  always_ff @(posedge clock) begin
    if (wr_accept) begin
      entries[wr_ptr] <= push_line;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count <= '0;
    end else begin
      if (wr_accept) begin
        wr_ptr <= (wr_ptr == ptr_bits'(wb_depth - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == ptr_bits'(wb_depth - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({wr_accept, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  a_no_push_full: assert property (
    @(posedge clock) disable iff (reset) push |-> !wb_full);

  a_no_done_empty: assert property (
    @(posedge clock) disable iff (reset) wb_done |-> wb_valid);

endmodule

// File: verilog/dcache.sv
// 4-way set-associative data cache with tree pseudo-LRU and writeback buffer
`timescale 1ns/100ps

module dcache #(
  parameter int wb_depth = 2
) (
  input  logic                              clock,
  input  logic                              reset,
  // read port
  input  dcache_geometry_pkg::dcache_addr_u rd_addr,
  input  logic                              rd_search,
  output logic                              rd_hit,
  output logic [63:0]                       rd_data,
  // write port, stores and fills
  input  dcache_port_pkg::wr_req_t          wr_req,
  input  logic                              wr_en,
  input  logic                              wr_fill,
  input  logic                              wr_search,
  output logic                              wr_hit,
  output dcache_port_pkg::victim_t          victim,
  // writeback side
  input  logic                              wb_done,
  output logic                              wb_valid,
  output dcache_port_pkg::victim_t          wb_line,
  output logic                              wb_full
);

  import dcache_geometry_pkg::*;
  import dcache_port_pkg::*;

  way_sel_t way_rd_hit;
  way_sel_t way_wr_hit;
  way_sel_t way_write;
  way_sel_t victim_way;

  logic [num_ways-1:0][data_bits-1:0] way_rd_data;
  victim_t [num_ways-1:0]             way_victim;

  victim_t fill_victim;
  logic    fill_strobe;
  logic    push;
  logic    rd_single;

  for (genvar w = 0; w < num_ways; w++) begin : g_way
    cache_way u_way (
      .clock   (clock),
      .reset   (reset),
      .wr_en   (way_write[w]),
      .rd_addr (rd_addr),
      .wr_req  (wr_req),
      .rd_hit  (way_rd_hit[w]),
      .rd_data (way_rd_data[w]),
      .wr_hit  (way_wr_hit[w]),
      .victim  (way_victim[w])
    );
  end

  assign rd_hit = |way_rd_hit;
  assign wr_hit = |way_wr_hit;

  // data only comes out on exactly one hitting way
  assign rd_single = (way_rd_hit != '0) && ((way_rd_hit & (way_rd_hit - 1'b1)) == '0);

  always_comb begin
    rd_data = '0;
    if (rd_search && rd_single) begin
      for (int i = 0; i < num_ways; i++) begin
        if (way_rd_hit[i]) begin
          rd_data = way_rd_data[i];
        end
      end
    end
  end

  // fill only on a miss; a hit turns the write into a store
  assign fill_strobe = wr_en && wr_fill && !wr_hit;

  always_comb begin
    if (wr_en && wr_hit) begin
      way_write = way_wr_hit;
    end else if (fill_strobe) begin
      way_write = victim_way;
    end else begin
      way_write = '0;
    end
  end

  plru_tree u_plru (
    .clock       (clock),
    .reset       (reset),
    .fill_strobe (fill_strobe),
    .fill_set    (wr_req.addr.fields.set_index),
    .victim_set  (wr_req.addr.fields.set_index),
    .victim_way  (victim_way)
  );

  // victim way's line for the write set
  always_comb begin
    fill_victim = '0;
    for (int i = 0; i < num_ways; i++) begin
      if (victim_way[i]) begin
        fill_victim = way_victim[i];
      end
    end
  end

  assign victim = wr_search ? fill_victim : '0;

  // only a valid dirty line needs to reach memory
  assign push = fill_strobe && fill_victim.valid && fill_victim.dirty;

  writeback_buffer #(
    .wb_depth (wb_depth)
  ) u_wb (
    .clock     (clock),
    .reset     (reset),
    .push      (push),
    .push_line (fill_victim),
    .wb_done   (wb_done),
    .wb_valid  (wb_valid),
    .wb_line   (wb_line),
    .wb_full   (wb_full)
  );

  // a tag lives in at most one way of a set
  a_unique_hit: assert property (
    @(posedge clock) disable iff (reset)
    $onehot0(way_rd_hit) && $onehot0(way_wr_hit)
  );

  // outside holds fills back while the buffer is full
  a_no_fill_full: assert property (
    @(posedge clock) disable iff (reset)
    wb_full |-> !(wr_en && wr_fill)
  );

endmodule

// File: tb/dcache_model.svh
// data cache reference model: line state, tree bits and writeback queue

logic                 line_valid [num_ways][num_sets];
logic                 line_dirty [num_ways][num_sets];
logic [tag_bits-1:0]  line_tag   [num_ways][num_sets];
logic [data_bits-1:0] line_data  [num_ways][num_sets];
logic                 tree_root  [num_sets];
logic                 tree_left  [num_sets];
logic                 tree_right [num_sets];
victim_t              wb_queue   [$];

task automatic clear_model();
  for (int s = 0; s < num_sets; s++) begin
    for (int w = 0; w < num_ways; w++) begin
      line_valid[w][s] = 1'b0;
      line_dirty[w][s] = 1'b0;
      line_tag[w][s] = '0;
      line_data[w][s] = '0;
    end
    tree_root[s] = 1'b0;
    tree_left[s] = 1'b0;
    tree_right[s] = 1'b0;
  end
  wb_queue.delete();
endtask

// way holding the tag, -1 on a miss
function automatic int find_hit(input logic [tag_bits-1:0] tag, input int idx);
  for (int w = 0; w < num_ways; w++) begin
    if (line_valid[w][idx] && (line_tag[w][idx] == tag)) begin
      return w;
    end
  end
  return -1;
endfunction

// root 0 looks at the left pair, root 1 at the right pair
function automatic int pick_victim(input int idx);
  if (!tree_root[idx]) begin
    return tree_left[idx] ? 1 : 0;
  end
  return tree_right[idx] ? 3 : 2;
endfunction

function automatic victim_t line_as_victim(input int way, input int idx);
  victim_t v;
  v.valid = line_valid[way][idx];
  v.dirty = line_dirty[way][idx];
  v.addr.fields.tag = line_tag[way][idx];
  v.addr.fields.set_index = index_bits'(idx);
  v.addr.fields.offset = '0;
  v.data = line_data[way][idx];
  return v;
endfunction

// state change at one clock edge
task automatic apply_cycle(input wr_req_t req, input logic en, input logic fill,
                           input logic done);
  int idx;
  int way;
  idx = req.addr.fields.set_index;
  way = find_hit(req.addr.fields.tag, idx);
  if (done && (wb_queue.size() != 0)) begin
    void'(wb_queue.pop_front());
  end
  if (en && fill && (way < 0)) begin
    way = pick_victim(idx);
    if (line_valid[way][idx] && line_dirty[way][idx]) begin
      wb_queue.push_back(line_as_victim(way, idx));
    end
    // old root decides which side flips
    if (tree_root[idx]) begin
      tree_right[idx] = !tree_right[idx];
    end else begin
      tree_left[idx] = !tree_left[idx];
    end
    tree_root[idx] = !tree_root[idx];
  end
  if (en && (way >= 0)) begin
    line_valid[way][idx] = 1'b1;
    line_dirty[way][idx] = req.dirty;
    line_tag[way][idx] = req.addr.fields.tag;
    line_data[way][idx] = req.data;
  end
endtask

// File: tb/dcache_tb.sv
// testbench for the 4-way data cache: random traffic checked against a model
`timescale 1ns/100ps

module dcache_tb;

  import dcache_geometry_pkg::*;
  import dcache_port_pkg::*;

  localparam int wb_depth = 2;
  localparam int num_ops = 3000;
  localparam int cycle_limit = 2 * num_ops + 100;

  logic         clock;
  logic         reset;
  dcache_addr_u rd_addr;
  logic         rd_search;
  logic         rd_hit;
  logic [63:0]  rd_data;
  wr_req_t      wr_req;
  logic         wr_en;
  logic         wr_fill;
  logic         wr_search;
  logic         wr_hit;
  victim_t      victim;
  logic         wb_done;
  logic         wb_valid;
  victim_t      wb_line;
  logic         wb_full;
  int           cycle_count = 0;

  `include "dcache_model.svh"

  dcache #(.wb_depth(wb_depth)) u_dcache (.*);

  always #10 clock = ~clock;

  always @(posedge clock) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= cycle_limit) begin
      $display("%0t: run did not finish within %0d cycles", $time, cycle_limit);
      $display("** FAIL **");
      $fatal(1, "timeout");
    end
  end

  task automatic report_mismatch(input string msg);
    $display("[FAIL] %0t: %s", $time, msg);
    $display("** FAIL **");
    $fatal(1, "stopping at first mismatch");
  endtask

  // six tags over three sets, so hits and evictions are common
  function automatic dcache_addr_u pool_address();
    dcache_addr_u a;
    a.fields.tag = 24'h5a0000 + tag_bits'($urandom_range(0, 5));
    a.fields.set_index = index_bits'(3 + 8 * $urandom_range(0, 2));
    a.fields.offset = offset_bits'($urandom_range(0, 7));
    return a;
  endfunction

  task automatic drive_random();
    wr_req_t req;
    int op;
    req.addr = pool_address();
    req.data = {$urandom, $urandom};
    op = $urandom_range(0, 4);
    // no fill while the buffer is full
    if ((op >= 3) && (wb_queue.size() >= wb_depth)) begin
      op = 1;
    end
    req.dirty = (op < 3);
    rd_addr <= pool_address();
    rd_search <= 1'($urandom_range(0, 1));
    wr_req <= req;
    wr_en <= (op != 0);
    wr_fill <= (op >= 3);
    wr_search <= 1'($urandom_range(0, 1));
    wb_done <= (wb_queue.size() != 0) && ($urandom_range(0, 1) == 1);
  endtask

  task automatic check_outputs();
    int rd_way;
    int wr_way;
    int wr_set;
    logic [63:0] exp_data;
    victim_t exp_victim;
    wr_set = wr_req.addr.fields.set_index;
    rd_way = find_hit(rd_addr.fields.tag, rd_addr.fields.set_index);
    wr_way = find_hit(wr_req.addr.fields.tag, wr_set);
    exp_data = '0;
    if (rd_search && (rd_way >= 0)) begin
      exp_data = line_data[rd_way][rd_addr.fields.set_index];
    end
    exp_victim = '0;
    if (wr_search) begin
      exp_victim = line_as_victim(pick_victim(wr_set), wr_set);
    end
    assert (rd_hit === (rd_way >= 0))
      else report_mismatch($sformatf("rd_hit %b for address %h", rd_hit, rd_addr.word));
    assert (rd_data === exp_data)
      else report_mismatch($sformatf("rd_data %h, expected %h", rd_data, exp_data));
    assert (wr_hit === (wr_way >= 0))
      else report_mismatch($sformatf("wr_hit %b for address %h", wr_hit, wr_req.addr.word));
    assert (victim === exp_victim)
      else report_mismatch($sformatf("victim %h, expected %h", victim, exp_victim));
    assert (wb_valid === (wb_queue.size() != 0))
      else report_mismatch($sformatf("wb_valid %b with %0d queued", wb_valid, wb_queue.size()));
    assert (wb_full === (wb_queue.size() == wb_depth))
      else report_mismatch($sformatf("wb_full %b with %0d queued", wb_full, wb_queue.size()));
    if (wb_queue.size() != 0) begin
      assert (wb_line === wb_queue[0])
        else report_mismatch($sformatf("wb_line %h, expected %h", wb_line, wb_queue[0]));
    end
  endtask

  initial begin
    clock = 1'b0;
    reset = 1'b1;
    rd_addr = '0;
    rd_search = 1'b0;
    wr_req = '0;
    wr_en = 1'b0;
    wr_fill = 1'b0;
    wr_search = 1'b0;
    wb_done = 1'b0;
    void'($urandom(29));
    clear_model();
    repeat (16) @(posedge clock);
    reset <= 1'b0;
    for (int n = 0; n < num_ops; n++) begin
      @(posedge clock);
      drive_random();
      @(negedge clock);
      check_outputs();
      apply_cycle(wr_req, wr_en, wr_fill, wb_done);
    end
    // memory takes whatever is still buffered
    while (wb_queue.size() != 0) begin
      @(posedge clock);
      wr_en <= 1'b0;
      wb_done <= 1'b1;
      @(negedge clock);
      check_outputs();
      apply_cycle(wr_req, wr_en, wr_fill, wb_done);
    end
    @(posedge clock);
    wb_done <= 1'b0;
    @(negedge clock);
    check_outputs();
    $display("** PASS **");
    $finish;
  end

endmodule

// File: vlog.f
+incdir+tb
verilog/dcache_geometry_pkg.sv
verilog/dcache_port_pkg.sv
verilog/cache_way.sv
verilog/plru_tree.sv
verilog/writeback_buffer.sv
verilog/dcache.sv
tb/dcache_tb.sv

// File: Bender.yml
package:
  name: dcache

sources:
  - verilog/dcache_geometry_pkg.sv
  - verilog/dcache_port_pkg.sv
  - verilog/cache_way.sv
  - verilog/plru_tree.sv
  - verilog/writeback_buffer.sv
  - verilog/dcache.sv
  - target: simulation
    include_dirs:
      - tb
    files:
      - tb/dcache_tb.sv
